/* hw/addr_translate.sv */
// segment decode, even/odd page select, exception checks and the
// registered response of one translation port
`timescale 1ns/1ps

module addr_translate
    import tlb_pkg::*;
    import cp0_tlb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  xlat_req_t         req,
    input  logic [ASID_W-1:0] asid,
    output logic [VPN2_W-1:0] lk_vpn2,
    output logic [ASID_W-1:0] lk_asid,
    input  tlb_lookup_t       lk_result,
    output xlat_rsp_t         rsp
);

    logic               unmapped;
    logic               kseg1;
    logic               odd;
    logic [PFN_W-1:0]   pfn;
    logic [CACHE_W-1:0] cattr;
    logic               dirty;
    logic               pvalid;
    xlat_rsp_t          rsp_d;

    assign lk_vpn2 = req.vaddr[31:32-VPN2_W];
    assign lk_asid = asid;

    // kseg0 starts at 0x8000_0000 and kseg1 at 0xa000_0000
    assign unmapped = (req.vaddr[31:30] == 2'b10);
    assign kseg1    = (req.vaddr[31:29] == 3'b101);

    // bit 12 picks the odd half of the pair
    assign odd    = req.vaddr[PAGE_OFS_W];
    assign pfn    = odd ? lk_result.entry.pfn1 : lk_result.entry.pfn0;
    assign cattr  = odd ? lk_result.entry.c1   : lk_result.entry.c0;
    assign dirty  = odd ? lk_result.entry.d1   : lk_result.entry.d0;
    assign pvalid = odd ? lk_result.entry.v1   : lk_result.entry.v0;

    always_comb begin
        rsp_d.valid = req.valid;
        if (unmapped) begin
            rsp_d.paddr    = {3'b000, req.vaddr[28:0]};
            rsp_d.cached   = ~kseg1;
            rsp_d.refill   = 1'b0;
            rsp_d.invalid  = 1'b0;
            rsp_d.modified = 1'b0;
        end else begin
            rsp_d.paddr    = {pfn, req.vaddr[PAGE_OFS_W-1:0]};
            rsp_d.cached   = (cattr == 3'd3);
            rsp_d.refill   = ~lk_result.found;
            rsp_d.invalid  = lk_result.found & ~pvalid;
            rsp_d.modified = lk_result.found & pvalid & req.store & ~dirty;
        end
    end

    // response one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp <= rsp_d;
        end
    end

endmodule

/* hw/cp0_tlb_pkg.sv */
// CP0 TLB register numbers, TLB op codes and the structs
// passed between the core, the translation units and the TLB
package cp0_tlb_pkg;
    import tlb_pkg::*;

    localparam logic [4:0] CP0_INDEX    = 5'd0;
    localparam logic [4:0] CP0_RANDOM   = 5'd1;
    localparam logic [4:0] CP0_ENTRYLO0 = 5'd2;
    localparam logic [4:0] CP0_ENTRYLO1 = 5'd3;
    localparam logic [4:0] CP0_WIRED    = 5'd6;
    localparam logic [4:0] CP0_ENTRYHI  = 5'd10;

    typedef enum logic [1:0] {
        TLBP  = 2'd0,
        TLBR  = 2'd1,
        TLBWI = 2'd2,
        TLBWR = 2'd3
    } tlb_op_e;

    typedef struct packed {
        logic        valid;
        logic        store;
        logic [31:0] vaddr;
    } xlat_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        cached;
        logic        refill;
        logic        invalid;
        logic        modified;
    } xlat_rsp_t;

    // result of one associative lookup
    typedef struct packed {
        logic       found;
        tlb_idx_t   idx;
        tlb_entry_t entry;
    } tlb_lookup_t;

endpackage

/* hw/mmu_top.sv */
// MMU top level: TLB array, CP0 TLB controller, Random counter
// and the instruction and data translation units
`timescale 1ns/1ps

module mmu_top
    import tlb_pkg::*;
    import cp0_tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    // translation
    input  xlat_req_t   ifetch_req,
    input  xlat_req_t   data_req,
    output xlat_rsp_t   ifetch_rsp,
    output xlat_rsp_t   data_rsp,
    // CP0 access
    input  logic        cp0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,
    // TLB ops
    input  logic        op_valid,
    input  tlb_op_e     op,
    output logic        op_busy,
    output logic        op_done
);

    logic              we;
    tlb_idx_t          w_index;
    tlb_entry_t        w_entry;
    tlb_idx_t          r_index;
    tlb_entry_t        r_entry;

    logic [ASID_W-1:0] asid;
    logic [VPN2_W-1:0] probe_vpn2;
    tlb_lookup_t       probe_result;

    logic [VPN2_W-1:0] if_vpn2;
    logic [ASID_W-1:0] if_asid;
    tlb_lookup_t       if_result;
    logic [VPN2_W-1:0] d_vpn2;
    logic [ASID_W-1:0] d_asid;
    tlb_lookup_t       d_result;

    tlb_idx_t          random;
    tlb_idx_t          wired;
    logic              wired_we;
    tlb_idx_t          wired_val;

    tlb_array u_tlb_array (
        .clk       (clk),
        .we        (we),
        .w_index   (w_index),
        .w_entry   (w_entry),
        .r_index   (r_index),
        .r_entry   (r_entry),
        .s0_vpn2   (if_vpn2),
        .s0_asid   (if_asid),
        .s0_result (if_result),
        .s1_vpn2   (d_vpn2),
        .s1_asid   (d_asid),
        .s1_result (d_result),
        .p_vpn2    (probe_vpn2),
        .p_asid    (asid),
        .p_result  (probe_result)
    );

    tlb_random_counter u_random (
        .clk       (clk),
        .rst_n     (rst_n),
        .wired_we  (wired_we),
        .wired_val (wired_val),
        .random    (random),
        .wired     (wired)
    );

    tlb_op_ctrl u_op_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cp0_we       (cp0_we),
        .cp0_addr     (cp0_addr),
        .cp0_wdata    (cp0_wdata),
        .cp0_rdata    (cp0_rdata),
        .op_valid     (op_valid),
        .op           (op),
        .op_busy      (op_busy),
        .op_done      (op_done),
        .asid         (asid),
        .probe_vpn2   (probe_vpn2),
        .probe_result (probe_result),
        .random       (random),
        .wired        (wired),
        .wired_we     (wired_we),
        .wired_val    (wired_val),
        .we           (we),
        .w_index      (w_index),
        .w_entry      (w_entry),
        .r_index      (r_index),
        .r_entry      (r_entry)
    );

    addr_translate u_ifetch_xlat (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (ifetch_req),
        .asid      (asid),
        .lk_vpn2   (if_vpn2),
        .lk_asid   (if_asid),
        .lk_result (if_result),
        .rsp       (ifetch_rsp)
    );

    addr_translate u_data_xlat (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (data_req),
        .asid      (asid),
        .lk_vpn2   (d_vpn2),
        .lk_asid   (d_asid),
        .lk_result (d_result),
        .rsp       (data_rsp)
    );

endmodule

/* hw/tlb_array.sv */
// fully associative TLB storage with one write port, one read port,
// two lookup ports for the core and one probe port for TLBP
`timescale 1ns/1ps

module tlb_array
    import tlb_pkg::*;
    import cp0_tlb_pkg::*;
(
    input  logic              clk,
    // write port
    input  logic              we,
    input  tlb_idx_t          w_index,
    input  tlb_entry_t        w_entry,
    // read port
    input  tlb_idx_t          r_index,
    output tlb_entry_t        r_entry,
    // lookup port 0, instruction side
    input  logic [VPN2_W-1:0] s0_vpn2,
    input  logic [ASID_W-1:0] s0_asid,
    output tlb_lookup_t       s0_result,
    // lookup port 1, data side
    input  logic [VPN2_W-1:0] s1_vpn2,
    input  logic [ASID_W-1:0] s1_asid,
    output tlb_lookup_t       s1_result,
    // probe port
    input  logic [VPN2_W-1:0] p_vpn2,
    input  logic [ASID_W-1:0] p_asid,
    output tlb_lookup_t       p_result
);

    tlb_entry_t        entries  [TLB_NUM];

    logic [VPN2_W-1:0] key_vpn2 [LOOKUP_PORTS];
    logic [ASID_W-1:0] key_asid [LOOKUP_PORTS];
    tlb_lookup_t       result   [LOOKUP_PORTS];

    // new contents show up in lookups from the next cycle
    always_ff @(posedge clk) begin
        if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    assign r_entry = entries[r_index];

    assign key_vpn2[0] = s0_vpn2;
    assign key_asid[0] = s0_asid;
    assign key_vpn2[1] = s1_vpn2;
    assign key_asid[1] = s1_asid;
    assign key_vpn2[2] = p_vpn2;
    assign key_asid[2] = p_asid;

    for (genvar p = 0; p < LOOKUP_PORTS; p++) begin : g_port
        logic [TLB_NUM-1:0] hit;
        tlb_idx_t           hit_idx;

        // global entries ignore the ASID
        for (genvar e = 0; e < TLB_NUM; e++) begin : g_match
            assign hit[e] = (entries[e].vpn2 == key_vpn2[p]) &&
                            (entries[e].g || (entries[e].asid == key_asid[p]));
        end

        // one-hot to binary, multiple hits give a meaningless index
        always_comb begin
            hit_idx = '0;
            for (int i = 0; i < TLB_NUM; i++) begin
                if (hit[i]) begin
                    hit_idx = hit_idx | tlb_idx_t'(i);
                end
            end
        end

        assign result[p].found = |hit;
        assign result[p].idx   = hit_idx;
        assign result[p].entry = entries[hit_idx];
    end

    assign s0_result = result[0];
    assign s1_result = result[1];
    assign p_result  = result[2];

endmodule

/* hw/tlb_op_ctrl.sv */
// CP0 Index, EntryHi and EntryLo registers, CP0 read/write decode
// and the FSM that runs TLBP, TLBR, TLBWI and TLBWR
`timescale 1ns/1ps

module tlb_op_ctrl
    import tlb_pkg::*;
    import cp0_tlb_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // CP0 access
    input  logic              cp0_we,
    input  logic [4:0]        cp0_addr,
    input  logic [31:0]       cp0_wdata,
    output logic [31:0]       cp0_rdata,
    // op interface
    input  logic              op_valid,
    input  tlb_op_e           op,
    output logic              op_busy,
    output logic              op_done,
    // lookup key and probe
    output logic [ASID_W-1:0] asid,
    output logic [VPN2_W-1:0] probe_vpn2,
    input  tlb_lookup_t       probe_result,
    // Random / Wired
    input  tlb_idx_t          random,
    input  tlb_idx_t          wired,
    output logic              wired_we,
    output tlb_idx_t          wired_val,
    // TLB write and read ports
    output logic              we,
    output tlb_idx_t          w_index,
    output tlb_entry_t        w_entry,
    output tlb_idx_t          r_index,
    input  tlb_entry_t        r_entry
);

    // EntryLo in MIPS bit order, pfn at [25:6] down to g at [0]
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        logic               d;
        logic               v;
        logic               g;
    } entrylo_t;

    localparam int ELO_W = $bits(entrylo_t);

    typedef enum logic {
        IDLE,
        EXEC
    } state_e;

    state_e            state;
    tlb_op_e           op_q;
    logic              index_p;
    tlb_idx_t          index_val;
    logic [VPN2_W-1:0] ehi_vpn2;
    logic [ASID_W-1:0] ehi_asid;
    entrylo_t          elo0;
    entrylo_t          elo1;
    logic              cp0_wr_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            op_done <= 1'b0;
        end else begin
            op_done <= (state == EXEC);
            if (state == IDLE && op_valid) begin
                state <= EXEC;
            end else begin
                state <= IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && op_valid) begin
            op_q <= op;
        end
    end

    assign op_busy = (state == EXEC);

    // software writes first, op results override in the same cycle
    always_ff @(posedge clk) begin
        if (cp0_we) begin
            case (cp0_addr)
                CP0_INDEX:    index_val <= cp0_wdata[TLB_IDX_W-1:0];
                CP0_ENTRYLO0: elo0      <= cp0_wdata[ELO_W-1:0];
                CP0_ENTRYLO1: elo1      <= cp0_wdata[ELO_W-1:0];
                CP0_ENTRYHI: begin
                    ehi_vpn2 <= cp0_wdata[31:32-VPN2_W];
                    ehi_asid <= cp0_wdata[ASID_W-1:0];
                end
                default: ;
            endcase
        end
        if (state == EXEC) begin
            case (op_q)
                TLBP: begin
                    index_p <= ~probe_result.found;
                    if (probe_result.found) begin
                        index_val <= probe_result.idx;
                    end
                end
                TLBR: begin
                    ehi_vpn2 <= r_entry.vpn2;
                    ehi_asid <= r_entry.asid;
                    elo0     <= {r_entry.pfn0, r_entry.c0, r_entry.d0, r_entry.v0, r_entry.g};
                    elo1     <= {r_entry.pfn1, r_entry.c1, r_entry.d1, r_entry.v1, r_entry.g};
                end
                default: ;
            endcase
        end
    end

    assign asid       = ehi_asid;
    assign probe_vpn2 = ehi_vpn2;
    assign r_index    = index_val;

    assign cp0_wr_hit = cp0_we && (cp0_addr == CP0_WIRED);
    assign wired_we   = cp0_wr_hit;
    assign wired_val  = cp0_wdata[TLB_IDX_W-1:0];

    assign we      = (state == EXEC) && (op_q == TLBWI || op_q == TLBWR);
    assign w_index = (op_q == TLBWR) ? random : index_val;

    // entry is global only if both halves say so
    assign w_entry = '{
        vpn2: ehi_vpn2,
        asid: ehi_asid,
        g:    elo0.g & elo1.g,
        pfn0: elo0.pfn,
        c0:   elo0.c,
        d0:   elo0.d,
        v0:   elo0.v,
        pfn1: elo1.pfn,
        c1:   elo1.c,
        d1:   elo1.d,
        v1:   elo1.v
    };

    always_comb begin
        case (cp0_addr)
            CP0_INDEX:    cp0_rdata = {index_p, {(31-TLB_IDX_W){1'b0}}, index_val};
            CP0_RANDOM:   cp0_rdata = {{(32-TLB_IDX_W){1'b0}}, random};
            CP0_ENTRYLO0: cp0_rdata = {{(32-ELO_W){1'b0}}, elo0};
            CP0_ENTRYLO1: cp0_rdata = {{(32-ELO_W){1'b0}}, elo1};
            CP0_WIRED:    cp0_rdata = {{(32-TLB_IDX_W){1'b0}}, wired};
            CP0_ENTRYHI:  cp0_rdata = {ehi_vpn2, {(32-VPN2_W-ASID_W){1'b0}}, ehi_asid};
            default:      cp0_rdata = '0;
        endcase
    end

endmodule

/* hw/tlb_pkg.sv */
// TLB geometry, field widths and the dual-page entry layout
// shared by the array, the CP0 controller and the translation units
package tlb_pkg;

    localparam int TLB_NUM      = 16;
    localparam int TLB_IDX_W    = $clog2(TLB_NUM);
    localparam int LOOKUP_PORTS = 3;

    // page field widths, 4 KB pages only
    localparam int VPN2_W     = 19;
    localparam int ASID_W     = 8;
    localparam int PFN_W      = 20;
    localparam int CACHE_W    = 3;
    localparam int PAGE_OFS_W = 12;

    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    // Random restarts here after a Wired write or a wrap
    localparam tlb_idx_t TLB_TOP_IDX = tlb_idx_t'(TLB_NUM - 1);

    // one entry maps an even/odd page pair
    typedef struct packed {
        logic [VPN2_W-1:0]  vpn2;
        logic [ASID_W-1:0]  asid;
        logic               g;
        // even page
        logic [PFN_W-1:0]   pfn0;
        logic [CACHE_W-1:0] c0;
        logic               d0;
        logic               v0;
        // odd page
        logic [PFN_W-1:0]   pfn1;
        logic [CACHE_W-1:0] c1;
        logic               d1;
        logic               v1;
    } tlb_entry_t;

endpackage

/* hw/tlb_random_counter.sv */
// CP0 Random and Wired registers
`timescale 1ns/1ps

module tlb_random_counter
    import tlb_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wired_we,
    input  tlb_idx_t wired_val,
    output tlb_idx_t random,
    output tlb_idx_t wired
);

    // counts down every cycle and never enters the wired range
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            random <= TLB_TOP_IDX;
            wired  <= '0;
        end else if (wired_we) begin
            random <= TLB_TOP_IDX;
            wired  <= wired_val;
        end else if (random <= wired) begin
            random <= TLB_TOP_IDX;
        end else begin
            random <= random - 1'b1;
        end
    end

endmodule

/* list.f */
hw/tlb_pkg.sv
hw/cp0_tlb_pkg.sv
hw/tlb_array.sv
hw/tlb_random_counter.sv
hw/tlb_op_ctrl.sv
hw/addr_translate.sv
hw/mmu_top.sv
+incdir+tests
tests/tb_mmu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -j 0 \
        --top-module tb_mmu_top --Mdir "$OBJ_DIR" -o sim_mmu -f list.f; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/sim_mmu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1

/* tests/tb_mmu_tasks.svh */
// compare task, CP0 access and TLB op tasks, a TLB reference model
// and the translation request stream
`ifndef TB_MMU_TASKS_SVH
`define TB_MMU_TASKS_SVH

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    #DRIVE_DLY;
    cp0_we    = 1'b1;
    cp0_addr  = addr;
    cp0_wdata = data;
    @(posedge clk);
    #DRIVE_DLY;
    cp0_we = 1'b0;
endtask

// sample the combinational cp0_rdata mid cycle
task automatic read_cp0(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk);
    #DRIVE_DLY;
    cp0_addr = addr;
    @(negedge clk);
    data = cp0_rdata;
endtask

task automatic run_op(input tlb_op_e code);
    int waited;
    @(posedge clk);
    #DRIVE_DLY;
    op_valid = 1'b1;
    op       = code;
    @(posedge clk);
    #DRIVE_DLY;
    op_valid = 1'b0;
    @(negedge clk);
    check({code.name(), " op_busy in EXEC"}, 32'(op_busy), 32'd1);
    waited = 1;
    while (op_done !== 1'b1 && waited < OP_TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (op_done !== 1'b1) begin
        err_count++;
        $display("%s did not raise op_done within %0d cycles", code.name(), OP_TIMEOUT);
    end else begin
        // one EXEC cycle before the done pulse
        check({code.name(), " done latency"}, 32'(waited), 32'd2);
        check({code.name(), " op_busy with op_done"}, 32'(op_busy), 32'd0);
    end
endtask

function automatic logic [31:0] make_hi(input logic [VPN2_W-1:0] vpn2,
                                        input logic [ASID_W-1:0] asid);
    return {vpn2, 5'b0, asid};
endfunction

function automatic logic [31:0] make_lo(input logic [PFN_W-1:0] pfn, input logic [2:0] c,
                                        input logic d, input logic v, input logic g);
    return {6'b0, pfn, c, d, v, g};
endfunction

function automatic logic [31:0] make_va(input logic [VPN2_W-1:0] vpn2, input logic odd,
                                        input logic [11:0] ofs);
    return {vpn2, odd, ofs};
endfunction

task automatic load_entry(input int idx, input logic [31:0] hi,
                          input logic [31:0] lo0, input logic [31:0] lo1);
    write_cp0(CP0_INDEX, 32'(idx));
    write_cp0(CP0_ENTRYHI, hi);
    write_cp0(CP0_ENTRYLO0, lo0);
    write_cp0(CP0_ENTRYLO1, lo1);
    run_op(TLBWI);
    model_hi[idx]  = hi & HI_MASK;
    model_lo0[idx] = lo0 & LO_MASK;
    model_lo1[idx] = lo1 & LO_MASK;
endtask

// TLBR returns the AND of both G bits in each EntryLo
task automatic verify_entry(input int idx);
    logic [31:0] rd;
    logic        g;
    g = model_lo0[idx][0] & model_lo1[idx][0];
    write_cp0(CP0_INDEX, 32'(idx));
    run_op(TLBR);
    read_cp0(CP0_ENTRYHI, rd);
    check($sformatf("EntryHi[%0d]", idx), rd, model_hi[idx]);
    read_cp0(CP0_ENTRYLO0, rd);
    check($sformatf("EntryLo0[%0d]", idx), rd, {model_lo0[idx][31:1], g});
    read_cp0(CP0_ENTRYLO1, rd);
    check($sformatf("EntryLo1[%0d]", idx), rd, {model_lo1[idx][31:1], g});
endtask

task automatic set_asid(input logic [ASID_W-1:0] asid);
    write_cp0(CP0_ENTRYHI, make_hi('0, asid));
    cur_asid = asid;
endtask

// reference translation over the model of the TLB contents
function automatic xlat_rsp_t expect_xlat(input xlat_req_t req, input logic [ASID_W-1:0] asid);
    xlat_rsp_t   r;
    logic [31:0] lo;
    logic        hit;
    logic        g;
    r       = '0;
    lo      = '0;
    hit     = 1'b0;
    r.valid = req.valid;
    if (req.vaddr[31:30] == 2'b10) begin
        r.paddr  = req.vaddr & 32'h1FFF_FFFF;
        r.cached = ~req.vaddr[29];
        return r;
    end
    for (int i = 0; i < TLB_NUM; i++) begin
        g = model_lo0[i][0] & model_lo1[i][0];
        if (model_hi[i][31:13] == req.vaddr[31:13] && (g || model_hi[i][7:0] == asid)) begin
            hit = 1'b1;
            lo  = req.vaddr[12] ? model_lo1[i] : model_lo0[i];
        end
    end
    r.refill   = ~hit;
    r.invalid  = hit & ~lo[1];
    r.modified = hit & lo[1] & req.store & ~lo[2];
    r.paddr    = {lo[25:6], req.vaddr[11:0]};
    r.cached   = (lo[5:3] == 3'd3);
    return r;
endfunction

task automatic compare_rsp(input string name, input xlat_rsp_t got, input xlat_rsp_t exp);
    check({name, ".valid"}, 32'(got.valid), 32'(exp.valid));
    check({name, ".refill"}, 32'(got.refill), 32'(exp.refill));
    check({name, ".invalid"}, 32'(got.invalid), 32'(exp.invalid));
    check({name, ".modified"}, 32'(got.modified), 32'(exp.modified));
    // address only meaningful without an exception
    if (!(exp.refill || exp.invalid || exp.modified)) begin
        check({name, ".paddr"}, got.paddr, exp.paddr);
        check({name, ".cached"}, 32'(got.cached), 32'(exp.cached));
    end
endtask

function automatic void queue_pair(input logic [31:0] if_va, input logic [31:0] d_va,
                                   input logic d_store);
    xlat_req_t ir;
    xlat_req_t dr;
    ir = '{valid: 1'b1, store: 1'b0, vaddr: if_va};
    dr = '{valid: 1'b1, store: d_store, vaddr: d_va};
    if_q.push_back(ir);
    d_q.push_back(dr);
    if_exp.push_back(expect_xlat(ir, cur_asid));
    d_exp.push_back(expect_xlat(dr, cur_asid));
endfunction

// one request per cycle on both ports with each response a cycle later
task automatic stream_requests();
    int n;
    n = if_q.size();
    for (int k = 0; k <= n; k++) begin
        @(posedge clk);
        #DRIVE_DLY;
        if (k < n) begin
            ifetch_req = if_q[k];
            data_req   = d_q[k];
        end else begin
            ifetch_req = '0;
            data_req   = '0;
        end
        @(negedge clk);
        if (k > 0) begin
            compare_rsp($sformatf("ifetch_rsp[%0d]", k - 1), ifetch_rsp, if_exp[k-1]);
            compare_rsp($sformatf("data_rsp[%0d]", k - 1), data_rsp, d_exp[k-1]);
        end
    end
    @(negedge clk);
    check("ifetch_rsp.valid idle", 32'(ifetch_rsp.valid), 32'd0);
    check("data_rsp.valid idle", 32'(data_rsp.valid), 32'd0);
    if_q.delete();
    d_q.delete();
    if_exp.delete();
    d_exp.delete();
endtask

`endif

/* tests/tb_mmu_top.sv */
// clock, reset, DUT instance, watchdog, directed MMU tests
// and the closing report
`timescale 1ns/1ps

module tb_mmu_top
    import tlb_pkg::*;
    import cp0_tlb_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 5;
    localparam int OP_TIMEOUT   = 10;

    // upper bounds on CP0 accesses, ops and requests in the test sequence
    localparam int CP0_ACCESSES = 250;
    localparam int OP_COUNT     = 70;
    localparam int XLAT_ITEMS   = 80;
    localparam int WATCHDOG_NS  = (CP0_ACCESSES * 2 + OP_COUNT * (OP_TIMEOUT + 2)
                                   + XLAT_ITEMS * 2 + RESET_CYCLES + 100) * CLK_PERIOD;

    localparam logic [31:0] HI_MASK = 32'hFFFF_E0FF;
    localparam logic [31:0] LO_MASK = 32'h03FF_FFFF;

    logic        clk;
    logic        rst_n;
    xlat_req_t   ifetch_req;
    xlat_req_t   data_req;
    xlat_rsp_t   ifetch_rsp;
    xlat_rsp_t   data_rsp;
    logic        cp0_we;
    logic [4:0]  cp0_addr;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;
    logic        op_valid;
    tlb_op_e     op;
    logic        op_busy;
    logic        op_done;

    int          err_count   = 0;
    int          check_count = 0;
    integer      seed        = 32'h539f;

    // model of the TLB contents in CP0 register layout
    logic [31:0]       model_hi  [TLB_NUM];
    logic [31:0]       model_lo0 [TLB_NUM];
    logic [31:0]       model_lo1 [TLB_NUM];
    logic [ASID_W-1:0] cur_asid;

    xlat_req_t if_q   [$];
    xlat_req_t d_q    [$];
    xlat_rsp_t if_exp [$];
    xlat_rsp_t d_exp  [$];

    `include "tb_mmu_tasks.svh"

    mmu_top i_mmu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ifetch_req (ifetch_req),
        .data_req   (data_req),
        .ifetch_rsp (ifetch_rsp),
        .data_rsp   (data_rsp),
        .cp0_we     (cp0_we),
        .cp0_addr   (cp0_addr),
        .cp0_wdata  (cp0_wdata),
        .cp0_rdata  (cp0_rdata),
        .op_valid   (op_valid),
        .op         (op),
        .op_busy    (op_busy),
        .op_done    (op_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic write_read_back();
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        // top nibble of vpn2 is the index so no two entries collide
        for (int i = 0; i < TLB_NUM; i++) begin
            hi  = make_hi({4'(i), 1'b0, 14'($random(seed))}, 8'($random(seed)));
            lo0 = 32'($random(seed)) & LO_MASK;
            lo1 = 32'($random(seed)) & LO_MASK;
            load_entry(i, hi, lo0, lo1);
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            verify_entry(i);
        end
    endtask

    task automatic probe_key(input logic [31:0] hi, input logic hit, input int idx);
        logic [31:0] rd;
        write_cp0(CP0_ENTRYHI, hi);
        run_op(TLBP);
        read_cp0(CP0_INDEX, rd);
        if (hit) begin
            check("Index after TLBP hit", rd, 32'(idx));
        end else begin
            check("Index.P after TLBP miss", 32'(rd[31]), 32'd1);
        end
    endtask

    task automatic probe_lookup();
        load_entry(5, make_hi({4'h5, 1'b0, 14'h0A5A}, 8'h21),
                   make_lo(20'h11111, 3'd3, 1'b1, 1'b1, 1'b0),
                   make_lo(20'h22222, 3'd3, 1'b1, 1'b1, 1'b0));
        load_entry(6, make_hi({4'h6, 1'b0, 14'h1234}, 8'h33),
                   make_lo(20'h66666, 3'd2, 1'b0, 1'b1, 1'b1),
                   make_lo(20'h77777, 3'd2, 1'b0, 1'b1, 1'b1));
        probe_key(make_hi({4'h5, 1'b0, 14'h0A5A}, 8'h21), 1'b1, 5);
        probe_key(make_hi({4'h5, 1'b0, 14'h0A5A}, 8'h44), 1'b0, 0);
        probe_key(make_hi({4'h6, 1'b0, 14'h1234}, 8'h99), 1'b1, 6);
        probe_key(model_hi[9], 1'b1, 9);
        probe_key(make_hi({4'h7, 1'b1, 14'h2222}, 8'h21), 1'b0, 0);
    endtask

    task automatic mapped_translation();
        logic [VPN2_W-1:0] vpn_tab [3];
        logic [11:0]       ofs;
        vpn_tab[0] = {4'h1, 1'b0, 14'h0123};
        vpn_tab[1] = {4'h2, 1'b0, 14'h0456};
        vpn_tab[2] = {4'hD, 1'b0, 14'h1F0F};
        load_entry(1, make_hi(vpn_tab[0], 8'h21),
                   make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
                   make_lo(20'hABCDE, 3'd2, 1'b1, 1'b1, 1'b0));
        // global pair under another ASID
        load_entry(2, make_hi(vpn_tab[1], 8'h07),
                   make_lo(20'h00F00, 3'd3, 1'b1, 1'b1, 1'b1),
                   make_lo(20'h55555, 3'd3, 1'b1, 1'b1, 1'b1));
        load_entry(13, make_hi(vpn_tab[2], 8'h21),
                   make_lo(20'hCAFE0, 3'd3, 1'b1, 1'b1, 1'b0),
                   make_lo(20'h0BEEF, 3'd0, 1'b1, 1'b1, 1'b0));
        set_asid(8'h21);
        for (int k = 0; k < 8; k++) begin
            ofs = 12'($random(seed));
            queue_pair(make_va(vpn_tab[k % 3], k[0], ofs),
                       make_va(vpn_tab[(k + 1) % 3], ~k[0], ~ofs), k[1]);
        end
        stream_requests();
    endtask

    task automatic exception_flags();
        logic [VPN2_W-1:0] vpn3;
        vpn3 = {4'h3, 1'b0, 14'h0777};
        // even page not valid and odd page valid but clean
        load_entry(3, make_hi(vpn3, 8'h21),
                   make_lo(20'h33333, 3'd3, 1'b1, 1'b0, 1'b0),
                   make_lo(20'h44444, 3'd3, 1'b0, 1'b1, 1'b0));
        set_asid(8'h21);
        queue_pair(make_va({4'h4, 1'b1, 14'h3FFF}, 1'b0, 12'h010),
                   make_va(vpn3, 1'b1, 12'h020), 1'b1);
        queue_pair(make_va(vpn3, 1'b0, 12'h030), make_va(vpn3, 1'b1, 12'h040), 1'b0);
        queue_pair(make_va({4'h1, 1'b0, 14'h0123}, 1'b1, 12'h050),
                   make_va(vpn3, 1'b0, 12'h060), 1'b1);
        stream_requests();
        // non-global entries stop matching under another ASID
        set_asid(8'h44);
        queue_pair(make_va({4'h1, 1'b0, 14'h0123}, 1'b0, 12'h070),
                   make_va({4'h2, 1'b0, 14'h0456}, 1'b1, 12'h080), 1'b0);
        queue_pair(make_va({4'h2, 1'b0, 14'h0456}, 1'b0, 12'h090),
                   make_va(vpn3, 1'b1, 12'h0A0), 1'b1);
        stream_requests();
    endtask

    task automatic unmapped_segments();
        logic [2:0] if_seg;
        logic [2:0] d_seg;
        // kseg keys that also hit in the TLB with other attributes
        load_entry(8, make_hi({4'h8, 1'b0, 14'h0321}, 8'h21),
                   make_lo(20'h0ABCD, 3'd2, 1'b0, 1'b1, 1'b0),
                   make_lo(20'h0DCBA, 3'd2, 1'b0, 1'b1, 1'b0));
        load_entry(10, make_hi({4'hA, 1'b0, 14'h0654}, 8'h21),
                   make_lo(20'h06543, 3'd3, 1'b1, 1'b1, 1'b0),
                   make_lo(20'h03456, 3'd3, 1'b1, 1'b1, 1'b0));
        set_asid(8'h21);
        for (int k = 0; k < 6; k++) begin
            if_seg = k[0] ? 3'b101 : 3'b100;
            d_seg  = k[0] ? 3'b100 : 3'b101;
            queue_pair({if_seg, 29'($random(seed))}, {d_seg, 29'($random(seed))}, k[1]);
        end
        queue_pair(make_va({4'hA, 1'b0, 14'h0654}, 1'b1, 12'h456),
                   make_va({4'h8, 1'b0, 14'h0321}, 1'b0, 12'h123), 1'b1);
        stream_requests();
    endtask

    task automatic random_writes();
        logic [31:0] rd;
        write_cp0(CP0_WIRED, 32'd4);
        read_cp0(CP0_WIRED, rd);
        check("Wired", rd, 32'd4);
        for (int k = 0; k < 4; k++) begin
            write_cp0(CP0_ENTRYHI, make_hi({4'(k), 1'b1, 14'h0155}, 8'h21));
            write_cp0(CP0_ENTRYLO0, 32'($random(seed)) & LO_MASK);
            write_cp0(CP0_ENTRYLO1, 32'($random(seed)) & LO_MASK);
            read_cp0(CP0_RANDOM, rd);
            check("Random at or above Wired", 32'(rd >= 32'd4), 32'd1);
            run_op(TLBWR);
            run_op(TLBP);
            read_cp0(CP0_INDEX, rd);
            check("Index.P after TLBWR", 32'(rd[31]), 32'd0);
            check("Index at or above Wired", 32'(rd[3:0] >= 4'd4), 32'd1);
        end
        // wired entries keep their contents
        for (int i = 0; i < 4; i++) begin
            verify_entry(i);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        ifetch_req = '0;
        data_req   = '0;
        cp0_we     = 1'b0;
        cp0_addr   = '0;
        cp0_wdata  = '0;
        op_valid   = 1'b0;
        op         = TLBP;
        cur_asid   = '0;

        repeat (RESET_CYCLES - 2) @(posedge clk);
        #DRIVE_DLY;
        cp0_addr = CP0_RANDOM;
        @(negedge clk);
        check("Random after reset", cp0_rdata, 32'(TLB_NUM - 1));
        check("op_busy after reset", 32'(op_busy), 32'd0);
        check("op_done after reset", 32'(op_done), 32'd0);
        check("ifetch_rsp.valid after reset", 32'(ifetch_rsp.valid), 32'd0);
        check("data_rsp.valid after reset", 32'(data_rsp.valid), 32'd0);
        @(posedge clk);
        #DRIVE_DLY;
        cp0_addr = CP0_WIRED;
        @(negedge clk);
        check("Wired after reset", cp0_rdata, 32'd0);
        @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        write_read_back();
        probe_lookup();
        mapped_translation();
        exception_flags();
        unmapped_segments();
        random_writes();

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("checks: %0d, errors: %0d", check_count, err_count + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule
